// File: hw/spin_defs.svh
`ifndef SPIN_DEFS_SVH
`define SPIN_DEFS_SVH

// Bits per spin vector
// One bit per Ising spin with a set bit for spin up
`define SPIN_WIDTH 16

// Entries in the spin FIFO between generator and counter
`define SPIN_DEPTH 4

// Width of the iteration index and of the iteration count
// Also sets the width of the beat counter in the report
`define ITER_W 8

`endif

// File: hw/spin_pkg.sv
`include "spin_defs.svh"

package spin_pkg;

    // One spin vector with a set bit for spin up
    typedef logic [`SPIN_WIDTH-1:0] spin_vec_t;

    // Iteration index carried next to each vector
    typedef logic [`ITER_W-1:0] iter_idx_t;

    // Payload through the spin FIFO
    // Consumer sees which annealing step a vector belongs to
    typedef struct packed {
        spin_vec_t spin;
        iter_idx_t iter;
    } spin_beat_t;

    // Popcount of one vector needs one bit more than log2 of the width
    localparam int unsigned POP_W = $clog2(`SPIN_WIDTH + 1);
    typedef logic [POP_W-1:0] pop_cnt_t;

endpackage

// File: hw/anneal_ctrl_pkg.sv
`include "spin_defs.svh"

package anneal_ctrl_pkg;

    import spin_pkg::*;

    // Host control levels of the anneal path
    typedef struct packed {
        logic en;
        logic flush;
        logic cmpt_en;
        logic host_readout;
    } anneal_ctrl_t;

    // Run configuration sampled by the generator on start
    typedef struct packed {
        spin_vec_t          seed;
        spin_vec_t          flip_mask;
        logic [`ITER_W-1:0] count;
    } anneal_cfg_t;

    // Magnetization report of the consumer
    typedef struct packed {
        pop_cnt_t           last_pop;
        logic [15:0]        sum;
        logic [`ITER_W-1:0] beats;
    } mag_report_t;

endpackage

// File: hw/spin_fifo.sv
`timescale 1ns/10ps

module spin_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned DEPTH     = 4,
    parameter int unsigned PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    parameter int unsigned CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             push_i,
    input  payload_t         data_i,
    input  logic             pop_i,
    output payload_t         data_o,
    output logic             full_o,
    output logic             empty_o,
    output logic [CNT_W-1:0] usage_o
);

    // Entry storage
    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    // Pointer step with wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q;

    // Overflow and underflow requests are dropped here
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // Head entry comes straight from memory
    assign data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            // Flush empties the buffer in one cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Occupancy holds when push and pop meet
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: hw/spin_fifo_maintainer.sv
`timescale 1ns/10ps

module spin_fifo_maintainer
    import spin_pkg::*;
    import anneal_ctrl_pkg::*;
#(
    parameter int unsigned DEPTH = 4,
    parameter int unsigned CNT_W = $clog2(DEPTH + 1)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  anneal_ctrl_t     ctrl_i,
    input  logic             icon_finish_i,
    input  logic             push_valid_i,
    input  spin_beat_t       push_beat_i,
    output logic             push_ready_o,
    output logic             pop_valid_o,
    output spin_beat_t       pop_beat_o,
    input  logic             pop_ready_i,
    output logic             cmpt_busy_o,
    output logic [CNT_W-1:0] usage_o
);

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;
    logic cmpt_busy_q;
    logic cmpt_stop;
    logic busy_set;
    logic busy_clr;

    // Beat buffer between generator and counter
    spin_fifo #(
        .payload_t (spin_beat_t),
        .DEPTH     (DEPTH),
        .CNT_W     (CNT_W)
    ) u_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (ctrl_i.flush),
        .push_i  (fifo_push),
        .data_i  (push_beat_i),
        .pop_i   (fifo_pop),
        .data_o  (pop_beat_o),
        .full_o  (fifo_full),
        .empty_o (fifo_empty),
        .usage_o (usage_o)
    );

    // Generator done and buffer full ends the computation
    assign cmpt_stop = icon_finish_i & fifo_full;

    // Release while computing and not finished, or on host readout
    assign pop_valid_o = ctrl_i.en & ~fifo_empty &
                         ((cmpt_busy_q & ~icon_finish_i) | ctrl_i.host_readout);
    assign fifo_pop    = pop_valid_o & pop_ready_i;

    assign push_ready_o = ~fifo_full & ctrl_i.en;
    assign fifo_push    = push_valid_i & push_ready_o;

    // Clear wins over set in the status register
    assign busy_set = ctrl_i.cmpt_en & ctrl_i.en;
    assign busy_clr = cmpt_stop | ctrl_i.flush;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || busy_clr) begin
            cmpt_busy_q <= 1'b0;
        end else if (busy_set) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign cmpt_busy_o = cmpt_busy_q;

endmodule

// File: hw/spin_flip_generator.sv
`timescale 1ns/10ps
`include "spin_defs.svh"

module spin_flip_generator
    import spin_pkg::*;
    import anneal_ctrl_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  anneal_cfg_t cfg_i,
    output logic        push_valid_o,
    output spin_beat_t  push_beat_o,
    input  logic        push_ready_i,
    output logic        icon_finish_o,
    output logic        busy_o
);

    // Current vector and run settings
    spin_vec_t          vec_q;
    spin_vec_t          mask_q;
    logic [`ITER_W-1:0] count_q;
    iter_idx_t          idx_q;
    iter_idx_t          idx_nxt;
    logic               valid_q;
    logic               finish_q;
    logic               accept;
    logic               last_beat;

    // Rotate left by the amount modulo the vector width
    function automatic spin_vec_t rotl(input spin_vec_t v, input iter_idx_t sh);
        iter_idx_t amt;
        amt = iter_idx_t'(sh % `SPIN_WIDTH);
        return (v << amt) | (v >> (`SPIN_WIDTH - amt));
    endfunction

    assign accept    = valid_q & push_ready_i;
    assign idx_nxt   = idx_q + 1'b1;
    assign last_beat = (idx_q == count_q - 1'b1);

    // Control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            finish_q <= 1'b0;
            idx_q    <= '0;
        end else if (start_i) begin
            // Empty run finishes at once
            idx_q    <= '0;
            valid_q  <= (cfg_i.count != '0);
            finish_q <= (cfg_i.count == '0);
        end else if (accept) begin
            if (last_beat) begin
                valid_q  <= 1'b0;
                finish_q <= 1'b1;
            end else begin
                idx_q <= idx_nxt;
            end
        end
    end

    // Vector steps by the mask rotated by the next index
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            vec_q   <= cfg_i.seed;
            mask_q  <= cfg_i.flip_mask;
            count_q <= cfg_i.count;
        end else if (accept && !last_beat) begin
            vec_q <= vec_q ^ rotl(mask_q, idx_nxt);
        end
    end

    // Beat held stable until accepted
    assign push_valid_o     = valid_q;
    assign push_beat_o.spin = vec_q;
    assign push_beat_o.iter = idx_q;
    assign icon_finish_o    = finish_q;
    assign busy_o           = valid_q;

endmodule

// File: hw/spin_magnet_counter.sv
`timescale 1ns/10ps

module spin_magnet_counter
    import spin_pkg::*;
    import anneal_ctrl_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        pop_valid_i,
    input  spin_beat_t  pop_beat_i,
    output logic        pop_ready_o,
    output mag_report_t report_o
);

    mag_report_t report_q;
    pop_cnt_t    pop_cnt;
    logic        accept;

    // Number of up spins in one vector
    function automatic pop_cnt_t popcount(input spin_vec_t v);
        pop_cnt_t n;
        n = '0;
        for (int i = 0; i < $bits(spin_vec_t); i++) begin
            n = n + v[i];
        end
        return n;
    endfunction

    // Slow downstream modelled by the stall level
    assign pop_ready_o = ~stall_i;
    assign accept      = pop_valid_i & pop_ready_o;
    assign pop_cnt     = popcount(pop_beat_i.spin);

    // Report survives a flush and clears only on reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            report_q <= '0;
        end else if (accept) begin
            report_q.last_pop <= pop_cnt;
            // Running magnetization sum wraps at 16 bits
            report_q.sum      <= report_q.sum + pop_cnt;
            report_q.beats    <= report_q.beats + 1'b1;
        end
    end

    assign report_o = report_q;

endmodule

// File: hw/spin_anneal_top.sv
`timescale 1ns/10ps
`include "spin_defs.svh"

module spin_anneal_top
    import spin_pkg::*;
    import anneal_ctrl_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                start_i,
    input  anneal_cfg_t                         cfg_i,
    input  anneal_ctrl_t                        ctrl_i,
    input  logic                                sink_stall_i,
    output logic                                cmpt_busy_o,
    output logic [$clog2(`SPIN_DEPTH + 1)-1:0] fifo_usage_o,
    output logic                                gen_busy_o,
    output mag_report_t                         report_o
);

    // Generator to maintainer
    logic       push_valid;
    spin_beat_t push_beat;
    logic       push_ready;
    logic       icon_finish;

    // Maintainer to counter
    logic       pop_valid;
    spin_beat_t pop_beat;
    logic       pop_ready;

    spin_flip_generator u_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .cfg_i         (cfg_i),
        .push_valid_o  (push_valid),
        .push_beat_o   (push_beat),
        .push_ready_i  (push_ready),
        .icon_finish_o (icon_finish),
        .busy_o        (gen_busy_o)
    );

    spin_fifo_maintainer #(
        .DEPTH (`SPIN_DEPTH)
    ) u_maint (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ctrl_i        (ctrl_i),
        .icon_finish_i (icon_finish),
        .push_valid_i  (push_valid),
        .push_beat_i   (push_beat),
        .push_ready_o  (push_ready),
        .pop_valid_o   (pop_valid),
        .pop_beat_o    (pop_beat),
        .pop_ready_i   (pop_ready),
        .cmpt_busy_o   (cmpt_busy_o),
        .usage_o       (fifo_usage_o)
    );

    spin_magnet_counter u_mag (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (sink_stall_i),
        .pop_valid_i (pop_valid),
        .pop_beat_i  (pop_beat),
        .pop_ready_o (pop_ready),
        .report_o    (report_o)
    );

endmodule

// File: verif/spin_anneal_assertions.sv
`timescale 1ns/10ps
`include "spin_defs.svh"

module spin_anneal_assertions
    import anneal_ctrl_pkg::*;
#(
    parameter int unsigned DEPTH = `SPIN_DEPTH
) (
    input logic                         clk_i,
    input logic                         rst_n_i,
    input anneal_ctrl_t                 ctrl_i,
    input logic                         push_valid_i,
    input logic                         push_ready_i,
    input logic                         pop_valid_i,
    input logic                         pop_ready_i,
    input logic                         cmpt_busy_i,
    input logic [$clog2(DEPTH + 1)-1:0] usage_i
);

    // Occupancy rebuilt from the two handshakes
    logic [$clog2(DEPTH + 1)-1:0] occ_q;
    logic                         push_xfer;
    logic                         pop_xfer;

    assign push_xfer = push_valid_i & push_ready_i;
    assign pop_xfer  = pop_valid_i & pop_ready_i;

    // Flush drops every held beat
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || ctrl_i.flush) begin
            occ_q <= '0;
        end else if (push_xfer && !pop_xfer) begin
            occ_q <= occ_q + 1'b1;
        end else if (pop_xfer && !push_xfer) begin
            occ_q <= occ_q - 1'b1;
        end
    end

    // A pop offer needs a beat that was pushed and not yet popped
    a_pop_needs_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_valid_i |-> (occ_q != '0))
        else $error("pop_valid is high while the FIFO is empty");

    // Full FIFO takes no more beats
    a_full_blocks_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (occ_q == DEPTH) |-> !push_ready_i)
        else $error("push_ready is high while the FIFO is full");

    // Flush clears the completion status on the next cycle
    a_flush_clears_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl_i.flush |=> !cmpt_busy_i)
        else $error("cmpt_busy still high one cycle after flush");

    // Occupancy bounded by the depth
    a_usage_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        usage_i <= DEPTH)
        else $error("FIFO usage above its depth");

endmodule

// File: verif/spin_anneal_tb.sv
`timescale 1ns/10ps
`include "spin_defs.svh"

module spin_anneal_tb
    import spin_pkg::*;
    import anneal_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DEPTH        = `SPIN_DEPTH;
    // Iteration counts of the runs
    // Watchdog budget follows from them
    localparam int N_NORMAL     = 6;
    localparam int N_STALL      = 10;
    localparam int N_FLUSH      = 8;
    localparam int N_OFF        = 5;
    localparam int ITER_SUM     = N_NORMAL + N_STALL + DEPTH + N_FLUSH + N_OFF;
    // Cycles allowed per iteration under random back-pressure
    localparam int STALL_FACTOR = 8;
    localparam int SLACK_CYCLES = 200;

    logic                               clk;
    logic                               rst_n;
    logic                               start;
    anneal_cfg_t                        cfg;
    anneal_ctrl_t                       ctrl;
    logic                               sink_stall;
    logic                               cmpt_busy;
    logic [$clog2(`SPIN_DEPTH + 1)-1:0] fifo_usage;
    logic                               gen_busy;
    mag_report_t                        report;

    integer    rand_seed;
    // Expected vector sequence of the current run
    spin_vec_t model_vec[$];
    // Expected counter state kept over all runs
    int        exp_beats;
    int        exp_sum;

    spin_anneal_top dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .cfg_i        (cfg),
        .ctrl_i       (ctrl),
        .sink_stall_i (sink_stall),
        .cmpt_busy_o  (cmpt_busy),
        .fifo_usage_o (fifo_usage),
        .gen_busy_o   (gen_busy),
        .report_o     (report)
    );

    bind spin_fifo_maintainer spin_anneal_assertions u_assert (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl_i),
        .push_valid_i (push_valid_i),
        .push_ready_i (push_ready_o),
        .pop_valid_i  (pop_valid_o),
        .pop_ready_i  (pop_ready_i),
        .cmpt_busy_i  (cmpt_busy_o),
        .usage_i      (usage_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    // Budget covers every run at the worst stall rate
    initial begin
        #(CLK_PERIOD * (ITER_SUM * STALL_FACTOR + SLACK_CYCLES));
        $display("Watchdog expired before all tests finished");
        stop_on_failure();
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // Bit i lands on bit i+k modulo the vector width
    function automatic spin_vec_t rotate_left(input spin_vec_t v, input int k);
        spin_vec_t r;
        for (int i = 0; i < `SPIN_WIDTH; i++) begin
            r[(i + k) % `SPIN_WIDTH] = v[i];
        end
        return r;
    endfunction

    function automatic int count_ones(input spin_vec_t v);
        spin_vec_t rest;
        int        n;
        rest = v;
        n    = 0;
        // Drop the lowest set bit per step
        while (rest != '0) begin
            rest = rest & (rest - 1'b1);
            n++;
        end
        return n;
    endfunction

    // Seed first, then XOR with the mask rotated by the step index
    task automatic build_model(input spin_vec_t seed, input spin_vec_t mask, input int count);
        model_vec.delete();
        model_vec.push_back(seed);
        for (int k = 1; k < count; k++) begin
            model_vec.push_back(model_vec[k - 1] ^ rotate_left(mask, k));
        end
    endtask

    task automatic account_beats(input int first, input int last);
        for (int k = first; k <= last; k++) begin
            exp_sum = exp_sum + count_ones(model_vec[k]);
            exp_beats++;
        end
    endtask

    task automatic check_report(input spin_vec_t last_vec);
        check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
        check_eq("report_o.sum", report.sum, exp_sum[15:0]);
        check_eq("report_o.last_pop", report.last_pop, count_ones(last_vec));
    endtask

    task automatic start_run(input spin_vec_t seed, input spin_vec_t mask, input int count);
        @(posedge clk);
        cfg.seed      <= seed;
        cfg.flip_mask <= mask;
        cfg.count     <= count[`ITER_W-1:0];
        start         <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_gen_idle(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (gen_busy) begin
            if (cycles > limit) begin
                $display("Timeout waiting for the generator to finish its run");
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_cmpt_idle(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cmpt_busy) begin
            if (cycles > limit) begin
                $display("Timeout waiting for the computation to stop");
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_fifo_level(input int level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (fifo_usage != level) begin
            if (cycles > limit) begin
                $display("Timeout waiting for the FIFO to reach level %0d", level);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Host readout releases whatever the FIFO still holds
    task automatic drain_fifo(input int limit);
        @(posedge clk);
        ctrl.host_readout <= 1'b1;
        wait_fifo_level(0, limit);
        @(posedge clk);
        ctrl.host_readout <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        check_eq("gen_busy_o", gen_busy, 0);
        check_eq("cmpt_busy_o", cmpt_busy, 0);
        check_eq("fifo_usage_o", fifo_usage, 0);
        check_eq("report_o", report, 0);
    endtask

    task automatic normal_run();
        spin_vec_t seed_v;
        spin_vec_t mask_v;
        seed_v = spin_vec_t'($random(rand_seed));
        mask_v = spin_vec_t'($random(rand_seed));
        @(posedge clk);
        ctrl.en      <= 1'b1;
        ctrl.cmpt_en <= 1'b1;
        // Status register follows one cycle later
        @(posedge clk);
        @(negedge clk);
        check_eq("cmpt_busy_o", cmpt_busy, 1);
        build_model(seed_v, mask_v, N_NORMAL);
        start_run(seed_v, mask_v, N_NORMAL);
        wait_gen_idle(N_NORMAL * STALL_FACTOR);
        // Finish holds back the last beat while all earlier ones went through
        check_eq("fifo_usage_o", fifo_usage, 1);
        account_beats(0, N_NORMAL - 2);
        check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
        drain_fifo(DEPTH * STALL_FACTOR);
        account_beats(N_NORMAL - 1, N_NORMAL - 1);
        check_report(model_vec[N_NORMAL - 1]);
    endtask

    task automatic back_pressure();
        spin_vec_t   seed_v;
        spin_vec_t   mask_v;
        logic [31:0] coin;
        int          cycles;
        seed_v = spin_vec_t'($random(rand_seed));
        mask_v = spin_vec_t'($random(rand_seed));
        cycles = 0;
        build_model(seed_v, mask_v, N_STALL);
        start_run(seed_v, mask_v, N_STALL);
        @(negedge clk);
        while (gen_busy) begin
            if (cycles > N_STALL * STALL_FACTOR) begin
                $display("Timeout waiting for the stalled run to finish");
                stop_on_failure();
            end
            @(posedge clk);
            coin = $random(rand_seed);
            sink_stall <= coin[0];
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        sink_stall <= 1'b0;
        drain_fifo(DEPTH * STALL_FACTOR);
        account_beats(0, N_STALL - 1);
        check_report(model_vec[N_STALL - 1]);
    endtask

    // Run of exactly DEPTH beats fills the FIFO as the generator finishes
    task automatic completion_stop();
        spin_vec_t seed_v;
        spin_vec_t mask_v;
        seed_v = spin_vec_t'($random(rand_seed));
        mask_v = spin_vec_t'($random(rand_seed));
        @(posedge clk);
        sink_stall <= 1'b1;
        @(negedge clk);
        check_eq("cmpt_busy_o", cmpt_busy, 1);
        build_model(seed_v, mask_v, DEPTH);
        start_run(seed_v, mask_v, DEPTH);
        wait_cmpt_idle(DEPTH * STALL_FACTOR);
        check_eq("fifo_usage_o", fifo_usage, DEPTH);
        check_eq("gen_busy_o", gen_busy, 0);
        check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
        @(posedge clk);
        sink_stall <= 1'b0;
        // Nothing leaves once the computation has stopped
        repeat (2 * DEPTH) begin
            @(negedge clk);
            check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
            check_eq("fifo_usage_o", fifo_usage, DEPTH);
            check_eq("cmpt_busy_o", cmpt_busy, 0);
        end
    endtask

    task automatic host_readout();
        drain_fifo(DEPTH * STALL_FACTOR);
        account_beats(0, DEPTH - 1);
        check_report(model_vec[DEPTH - 1]);
    endtask

    task automatic flush_mid_run();
        @(posedge clk);
        sink_stall <= 1'b1;
        start_run(spin_vec_t'($random(rand_seed)), spin_vec_t'($random(rand_seed)), N_FLUSH);
        wait_fifo_level(2, N_FLUSH * STALL_FACTOR);
        @(posedge clk);
        ctrl.flush <= 1'b1;
        @(posedge clk);
        ctrl.flush <= 1'b0;
        @(negedge clk);
        check_eq("fifo_usage_o", fifo_usage, 0);
        check_eq("cmpt_busy_o", cmpt_busy, 0);
        check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
        // Generator kept pushing after the first flush
        // Park the path with en low and a second flush
        @(posedge clk);
        ctrl.en      <= 1'b0;
        ctrl.cmpt_en <= 1'b0;
        ctrl.flush   <= 1'b1;
        @(posedge clk);
        ctrl.flush <= 1'b0;
        sink_stall <= 1'b0;
        @(negedge clk);
        check_eq("fifo_usage_o", fifo_usage, 0);
        check_eq("cmpt_busy_o", cmpt_busy, 0);
    endtask

    task automatic enable_off();
        start_run(spin_vec_t'($random(rand_seed)), spin_vec_t'($random(rand_seed)), N_OFF);
        repeat (N_OFF * STALL_FACTOR) begin
            @(negedge clk);
            check_eq("fifo_usage_o", fifo_usage, 0);
            check_eq("report_o.beats", report.beats, exp_beats[`ITER_W-1:0]);
        end
        // First beat waits for push_ready
        check_eq("gen_busy_o", gen_busy, 1);
    endtask

    initial begin
        rand_seed  = 32'he910_61b3;
        exp_beats  = 0;
        exp_sum    = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        cfg        = '0;
        ctrl       = '0;
        sink_stall = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        normal_run();
        back_pressure();
        completion_stop();
        host_readout();
        flush_mid_run();
        enable_off();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/spin_pkg.sv
hw/anneal_ctrl_pkg.sv
hw/spin_fifo.sv
hw/spin_fifo_maintainer.sv
hw/spin_flip_generator.sv
hw/spin_magnet_counter.sv
hw/spin_anneal_top.sv
verif/spin_anneal_assertions.sv
verif/spin_anneal_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the spin anneal testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f all.f --top-module spin_anneal_tb -o spin_anneal_sim

./obj_dir/spin_anneal_sim
